// File: logic/tinker_pkg.sv
package tinker_pkg;

    // datapath widths
    localparam int XLEN       = 64;  // register and data width
    localparam int INSTR_W    = 32;  // every instruction is one word
    localparam int REG_ADDR_W = 5;   // 32 registers
    localparam int LIT_W      = 12;  // literal field
    localparam int ADDR_W     = 32;  // byte addresses

    // memory map
    localparam logic [ADDR_W-1:0] PC_RESET_ADDR = 32'h0000_2000;  // program base
    localparam int                MEM_BYTES     = 16384;          // also r31 at reset

    // mov r0,r0 is opcode 0x11 with all register fields zero
    localparam logic [INSTR_W-1:0] NOP_INSTR = 32'h8800_0000;

    // opcode field of every kept instruction
    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,  // rt ignored
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,  // rd >> L
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,  // rd << L
        OP_BRR_L  = 5'h0a,  // pc relative with L in words
        OP_HALT   = 5'h0f,
        OP_LOAD   = 5'h10,  // rd <- mem64[rs+L]
        OP_MOV_RS = 5'h11,
        OP_MOV_L  = 5'h12,  // low 12 bits of rd replaced
        OP_STORE  = 5'h13,  // mem64[rd+L] <- rs
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,  // rd + L
        OP_SUB    = 5'h1a,
        OP_SUBI   = 5'h1b   // rd - L
    } opcode_e;

endpackage

// File: logic/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           stall,         // load-use hold
    input  logic                           branch_taken,  // brr L resolved in ID
    input  logic                           halt_id,
    input  logic [tinker_pkg::ADDR_W-1:0]  branch_target,
    input  logic [tinker_pkg::INSTR_W-1:0] instr_if,      // from fetch port of memory
    output logic [tinker_pkg::ADDR_W-1:0]  pc_if,
    output logic [tinker_pkg::ADDR_W-1:0]  pc_id,
    output logic [tinker_pkg::INSTR_W-1:0] instr_id
);

    logic halted;  // sticky once halt left ID
    logic squash;  // kill whatever is being fetched

    assign squash = branch_taken || halt_id || halted;

    // program counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_if  <= tinker_pkg::PC_RESET_ADDR;
            halted <= 1'b0;
        end else if (!stall) begin
            if (halt_id)
                halted <= 1'b1;  // pc frozen from here on
            if (!halt_id && !halted)
                pc_if <= branch_taken ? branch_target : pc_if + 32'd4;
        end
    end

    // IF/ID register, stall has priority so a held instruction is never lost
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc_id    <= '0;
            instr_id <= tinker_pkg::NOP_INSTR;
        end else if (!stall) begin
            pc_id    <= pc_if;
            instr_id <= squash ? tinker_pkg::NOP_INSTR : instr_if;
        end
    end

endmodule

// File: logic/decode_unit.sv
`timescale 1ns/10ps

module decode_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              stall,
    input  logic [tinker_pkg::ADDR_W-1:0]     pc_id,
    input  logic [tinker_pkg::INSTR_W-1:0]    instr_id,
    input  logic [tinker_pkg::XLEN-1:0]       rf_rd_val,
    input  logic [tinker_pkg::XLEN-1:0]       rf_rs_val,
    input  logic [tinker_pkg::XLEN-1:0]       rf_rt_val,
    output logic [tinker_pkg::REG_ADDR_W-1:0] rd_id,
    output logic [tinker_pkg::REG_ADDR_W-1:0] rs_id,
    output logic [tinker_pkg::REG_ADDR_W-1:0] rt_id,
    output logic                              branch_taken,
    output logic                              halt_id,
    output logic [tinker_pkg::ADDR_W-1:0]     branch_target,
    output tinker_pkg::opcode_e               ex_opcode,
    output logic [tinker_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic [tinker_pkg::REG_ADDR_W-1:0] ex_rs,
    output logic [tinker_pkg::REG_ADDR_W-1:0] ex_rt,
    output logic [tinker_pkg::XLEN-1:0]       ex_rd_val,
    output logic [tinker_pkg::XLEN-1:0]       ex_rs_val,
    output logic [tinker_pkg::XLEN-1:0]       ex_rt_val,
    output logic [tinker_pkg::LIT_W-1:0]      ex_lit,
    output logic                              ex_reg_write,
    output logic                              ex_mem_read,
    output logic                              ex_mem_write,
    output logic                              ex_is_halt
);

    tinker_pkg::opcode_e          op;
    logic [tinker_pkg::LIT_W-1:0] lit;
    logic                         no_regs;  // brr L and halt read nothing
    logic                         reg_write, mem_read, mem_write;

    // field split
    assign op  = tinker_pkg::opcode_e'(instr_id[31:27]);
    assign lit = instr_id[11:0];

    // register-free formats present r0 so they never look like a load-use hazard
    assign no_regs = (op == tinker_pkg::OP_BRR_L) || (op == tinker_pkg::OP_HALT);
    assign rd_id   = no_regs ? '0 : instr_id[26:22];
    assign rs_id   = no_regs ? '0 : instr_id[21:17];
    assign rt_id   = no_regs ? '0 : instr_id[16:12];

    // control decode
    always_comb begin
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        case (op)
            tinker_pkg::OP_AND, tinker_pkg::OP_OR, tinker_pkg::OP_XOR, tinker_pkg::OP_NOT,
            tinker_pkg::OP_SHFTR, tinker_pkg::OP_SHFTRI, tinker_pkg::OP_SHFTL,
            tinker_pkg::OP_SHFTLI, tinker_pkg::OP_MOV_RS, tinker_pkg::OP_MOV_L,
            tinker_pkg::OP_ADD, tinker_pkg::OP_ADDI, tinker_pkg::OP_SUB,
            tinker_pkg::OP_SUBI: reg_write = 1'b1;
            tinker_pkg::OP_LOAD: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            tinker_pkg::OP_STORE: mem_write = 1'b1;
            default: ;  // brr L, halt and unknown opcodes have no side effects here
        endcase
        if (rd_id == '0) begin
            reg_write = 1'b0;  // r0 stays zero
            mem_read  = 1'b0;  // a load into r0 has nothing to do
        end
    end

    // brr L and halt resolve here
    assign branch_taken  = (op == tinker_pkg::OP_BRR_L);
    assign halt_id       = (op == tinker_pkg::OP_HALT);
    assign branch_target = pc_id + {{(tinker_pkg::ADDR_W-tinker_pkg::LIT_W-2){lit[11]}},
                                    lit, 2'b00};  // L counts words

    // ID/EX control with a bubble on stall or taken branch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_is_halt   <= 1'b0;
        end else if (stall || branch_taken) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_is_halt   <= 1'b0;
        end else begin
            ex_reg_write <= reg_write;
            ex_mem_read  <= mem_read;
            ex_mem_write <= mem_write;
            ex_is_halt   <= halt_id;
        end
    end

    // ID/EX payload is ignored while the control bits hold a bubble
    always_ff @(posedge clk) begin
        ex_opcode <= op;
        ex_rd     <= rd_id;
        ex_rs     <= rs_id;
        ex_rt     <= rt_id;
        ex_rd_val <= rf_rd_val;
        ex_rs_val <= rf_rs_val;
        ex_rt_val <= rf_rt_val;
        ex_lit    <= lit;
    end

    // the hazard unit must never hold a branch in ID
    a_no_stall_on_branch: assert property (
        @(posedge clk) disable iff (reset) !(stall && branch_taken)
    );

endmodule

// File: logic/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              wb_valid,  // never set for r0
    input  logic [tinker_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic [tinker_pkg::REG_ADDR_W-1:0] rd_id,
    input  logic [tinker_pkg::REG_ADDR_W-1:0] rs_id,
    input  logic [tinker_pkg::REG_ADDR_W-1:0] rt_id,
    input  logic [tinker_pkg::XLEN-1:0]       wb_data,
    output logic [tinker_pkg::XLEN-1:0]       rf_rd_val,
    output logic [tinker_pkg::XLEN-1:0]       rf_rs_val,
    output logic [tinker_pkg::XLEN-1:0]       rf_rt_val
);

    logic [tinker_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 31; i++)
                regs[i] <= '0;
            regs[31] <= tinker_pkg::XLEN'(tinker_pkg::MEM_BYTES);  // stack starts at top
        end else if (wb_valid) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-through: a same-cycle writeback wins over the stored value
    assign rf_rd_val = (wb_valid && wb_rd == rd_id) ? wb_data : regs[rd_id];
    assign rf_rs_val = (wb_valid && wb_rd == rs_id) ? wb_data : regs[rs_id];
    assign rf_rt_val = (wb_valid && wb_rd == rt_id) ? wb_data : regs[rt_id];

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
    input  logic                              ex_mem_read,  // load in ID/EX
    input  logic [tinker_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic [tinker_pkg::REG_ADDR_W-1:0] rd_id,
    input  logic [tinker_pkg::REG_ADDR_W-1:0] rs_id,
    input  logic [tinker_pkg::REG_ADDR_W-1:0] rt_id,
    output logic                              stall
);

    logic uses_load_rd;  // any field in ID names the load target

    // load data only exists after MEM, one cycle too late for EX forwarding
    // all three fields checked, every format may read any of them
    assign uses_load_rd = (ex_rd == rd_id) || (ex_rd == rs_id) || (ex_rd == rt_id);

    // ex_mem_read already implies ex_rd != 0
    assign stall = ex_mem_read && uses_load_rd;

endmodule

// File: logic/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  tinker_pkg::opcode_e               ex_opcode,
    input  logic [tinker_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic [tinker_pkg::REG_ADDR_W-1:0] ex_rs,
    input  logic [tinker_pkg::REG_ADDR_W-1:0] ex_rt,
    input  logic [tinker_pkg::XLEN-1:0]       ex_rd_val,
    input  logic [tinker_pkg::XLEN-1:0]       ex_rs_val,
    input  logic [tinker_pkg::XLEN-1:0]       ex_rt_val,
    input  logic [tinker_pkg::LIT_W-1:0]      ex_lit,
    input  logic                              ex_reg_write,
    input  logic                              ex_mem_read,
    input  logic                              ex_mem_write,
    input  logic                              ex_is_halt,
    input  logic                              wb_valid,
    input  logic [tinker_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic [tinker_pkg::XLEN-1:0]       wb_data,
    output logic [tinker_pkg::XLEN-1:0]       mem_result,      // ALU out or address
    output logic [tinker_pkg::XLEN-1:0]       mem_store_data,
    output logic [tinker_pkg::REG_ADDR_W-1:0] mem_rd,
    output logic                              mem_reg_write,
    output logic                              mem_read,
    output logic                              mem_write,
    output logic                              mem_is_halt
);

    logic [tinker_pkg::XLEN-1:0] rd_op, rs_op, rt_op;  // forwarded operands
    logic [tinker_pkg::XLEN-1:0] lit_ext;
    logic [tinker_pkg::XLEN-1:0] alu_out;

    // newest producer wins, EX/MEM is read straight off this module's outputs
    function automatic logic [tinker_pkg::XLEN-1:0] pick(
        input logic [tinker_pkg::REG_ADDR_W-1:0] idx,
        input logic [tinker_pkg::XLEN-1:0]       id_val
    );
        if (mem_reg_write && mem_rd == idx)
            return mem_result;
        else if (wb_valid && wb_rd == idx)
            return wb_data;
        return id_val;
    endfunction

    always_comb begin
        rd_op = pick(ex_rd, ex_rd_val);
        rs_op = pick(ex_rs, ex_rs_val);
        rt_op = pick(ex_rt, ex_rt_val);
    end

    assign lit_ext = {{(tinker_pkg::XLEN-tinker_pkg::LIT_W){1'b0}}, ex_lit};  // zero extend

    always_comb begin
        case (ex_opcode)
            tinker_pkg::OP_AND:    alu_out = rs_op & rt_op;
            tinker_pkg::OP_OR:     alu_out = rs_op | rt_op;
            tinker_pkg::OP_XOR:    alu_out = rs_op ^ rt_op;
            tinker_pkg::OP_NOT:    alu_out = ~rs_op;
            tinker_pkg::OP_SHFTR:  alu_out = rs_op >> rt_op;
            tinker_pkg::OP_SHFTRI: alu_out = rd_op >> lit_ext;
            tinker_pkg::OP_SHFTL:  alu_out = rs_op << rt_op;
            tinker_pkg::OP_SHFTLI: alu_out = rd_op << lit_ext;
            tinker_pkg::OP_ADD:    alu_out = rs_op + rt_op;
            tinker_pkg::OP_ADDI:   alu_out = rd_op + lit_ext;
            tinker_pkg::OP_SUB:    alu_out = rs_op - rt_op;
            tinker_pkg::OP_SUBI:   alu_out = rd_op - lit_ext;
            tinker_pkg::OP_MOV_RS: alu_out = rs_op;
            tinker_pkg::OP_MOV_L:  alu_out = {rd_op[tinker_pkg::XLEN-1:tinker_pkg::LIT_W], ex_lit};
            tinker_pkg::OP_LOAD:   alu_out = rs_op + lit_ext;  // base rs
            tinker_pkg::OP_STORE:  alu_out = rd_op + lit_ext;  // base rd
            default:               alu_out = '0;
        endcase
    end

    // EX/MEM control
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_reg_write <= 1'b0;
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
            mem_is_halt   <= 1'b0;
        end else begin
            mem_reg_write <= ex_reg_write;
            mem_read      <= ex_mem_read;
            mem_write     <= ex_mem_write;
            mem_is_halt   <= ex_is_halt;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        mem_result     <= alu_out;
        mem_store_data <= rs_op;  // store source is rs
        mem_rd         <= ex_rd;
    end

    // decode never marks one instruction as both load and store
    a_rw_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(mem_read && mem_write)
    );

endmodule

// File: logic/memory_unit.sv
`timescale 1ns/10ps

module memory_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [tinker_pkg::ADDR_W-1:0]     pc_if,
    input  logic [tinker_pkg::XLEN-1:0]       mem_result,
    input  logic [tinker_pkg::XLEN-1:0]       mem_store_data,
    input  logic [tinker_pkg::REG_ADDR_W-1:0] mem_rd,
    input  logic                              mem_reg_write,
    input  logic                              mem_read,
    input  logic                              mem_write,
    input  logic                              mem_is_halt,
    output logic [tinker_pkg::INSTR_W-1:0]    instr_if,
    output logic                              wb_valid,
    output logic [tinker_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [tinker_pkg::XLEN-1:0]       wb_data,
    output logic                              hlt
);

    logic [7:0]                    mem_bytes [tinker_pkg::MEM_BYTES];  // code and data
    logic [tinker_pkg::ADDR_W-1:0] data_addr;
    logic [tinker_pkg::XLEN-1:0]   load_data;
    logic                          wb_is_halt;

    assign data_addr = mem_result[tinker_pkg::ADDR_W-1:0];

    // little endian reads with 4 bytes for fetch and 8 for load
    always_comb begin
        for (int i = 0; i < 4; i++)
            instr_if[8*i +: 8] = mem_bytes[pc_if + i];
        for (int i = 0; i < 8; i++)
            load_data[8*i +: 8] = mem_bytes[data_addr + i];
    end

    // 8-byte little endian store port
    always @(posedge clk) begin
        if (mem_write)
            for (int i = 0; i < 8; i++)
                mem_bytes[data_addr + i] <= mem_store_data[8*i +: 8];
    end

    // MEM/WB control and halt flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid   <= 1'b0;
            wb_is_halt <= 1'b0;
            hlt        <= 1'b0;
        end else begin
            wb_valid   <= mem_reg_write;
            wb_is_halt <= mem_is_halt;
            if (wb_is_halt)
                hlt <= 1'b1;  // sticky since everything older has retired
        end
    end

    // MEM/WB payload with the writeback select
    always_ff @(posedge clk) begin
        wb_rd   <= mem_rd;
        wb_data <= mem_read ? load_data : mem_result;
    end

    // whole 8-byte store has to fit in the array
    a_store_in_range: assert property (
        @(posedge clk) disable iff (reset)
        mem_write |-> (data_addr <= tinker_pkg::ADDR_W'(tinker_pkg::MEM_BYTES - 8))
    );

endmodule

// File: logic/tinker_core.sv
`timescale 1ns/10ps

module tinker_core (
    input  logic                              clk,
    input  logic                              reset,
    output logic                              hlt,
    output logic                              wb_valid,  // one pulse per register write
    output logic [tinker_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [tinker_pkg::XLEN-1:0]       wb_data
);

    // IF <-> memory, IF -> ID
    logic [tinker_pkg::ADDR_W-1:0]     pc_if, pc_id, branch_target;
    logic [tinker_pkg::INSTR_W-1:0]    instr_if, instr_id;
    logic                              branch_taken, halt_id, stall;

    // register read ports
    logic [tinker_pkg::REG_ADDR_W-1:0] rd_id, rs_id, rt_id;
    logic [tinker_pkg::XLEN-1:0]       rf_rd_val, rf_rs_val, rf_rt_val;

    // ID/EX contents
    tinker_pkg::opcode_e               ex_opcode;
    logic [tinker_pkg::REG_ADDR_W-1:0] ex_rd, ex_rs, ex_rt;
    logic [tinker_pkg::XLEN-1:0]       ex_rd_val, ex_rs_val, ex_rt_val;
    logic [tinker_pkg::LIT_W-1:0]      ex_lit;
    logic                              ex_reg_write, ex_mem_read, ex_mem_write, ex_is_halt;

    // EX/MEM contents
    logic [tinker_pkg::XLEN-1:0]       mem_result, mem_store_data;
    logic [tinker_pkg::REG_ADDR_W-1:0] mem_rd;
    logic                              mem_reg_write, mem_read, mem_write, mem_is_halt;

    fetch_unit u_fetch (.*);

    decode_unit u_decode (.*);

    register_file u_regs (.*);

    hazard_unit u_hazard (.*);

    execute_unit u_execute (.*);

    memory_unit u_memory (.*);

endmodule

// File: testbench/tinker_model.svh
`ifndef TINKER_MODEL_SVH
`define TINKER_MODEL_SVH

// instruction-level reference, one instruction per loop pass
logic [7:0]  model_mem  [tinker_pkg::MEM_BYTES];
logic [63:0] model_regs [32];
logic [4:0]  exp_rd_q   [$];  // expected writebacks, program order
logic [63:0] exp_data_q [$];

function automatic logic [63:0] model_read64(input logic [31:0] addr);
    logic [63:0] v;
    for (int i = 0; i < 8; i++)
        v[8*i +: 8] = model_mem[addr + i];  // little endian
    return v;
endfunction

task automatic model_write_reg(input logic [4:0] idx, input logic [63:0] val);
    if (idx != 5'd0) begin  // r0 writes vanish
        model_regs[idx] = val;
        exp_rd_q.push_back(idx);
        exp_data_q.push_back(val);
    end
endtask

task automatic run_model();
    logic [31:0]         pc;
    logic [31:0]         ins;
    tinker_pkg::opcode_e op;
    logic [4:0]          rd, rs, rt;
    logic [63:0]         vd, vs, vt, lit;
    int                  steps;
    foreach (model_regs[i])
        model_regs[i] = '0;
    model_regs[31] = 64'(tinker_pkg::MEM_BYTES);  // stack top
    pc    = tinker_pkg::PC_RESET_ADDR;
    steps = 0;
    op    = tinker_pkg::OP_AND;
    while (op != tinker_pkg::OP_HALT) begin
        assert (steps < 1000) else
            report_failure("reference model ran past 1000 instructions without a halt");
        steps++;
        for (int i = 0; i < 4; i++)
            ins[8*i +: 8] = model_mem[pc + i];
        op  = tinker_pkg::opcode_e'(ins[31:27]);
        rd  = ins[26:22];
        rs  = ins[21:17];
        rt  = ins[16:12];
        vd  = model_regs[rd];
        vs  = model_regs[rs];
        vt  = model_regs[rt];
        lit = 64'(ins[11:0]);  // L is unsigned outside brr
        pc  = pc + 32'd4;
        case (op)
            tinker_pkg::OP_AND:    model_write_reg(rd, vs & vt);
            tinker_pkg::OP_OR:     model_write_reg(rd, vs | vt);
            tinker_pkg::OP_XOR:    model_write_reg(rd, vs ^ vt);
            tinker_pkg::OP_NOT:    model_write_reg(rd, ~vs);
            tinker_pkg::OP_SHFTR:  model_write_reg(rd, vs >> vt);
            tinker_pkg::OP_SHFTRI: model_write_reg(rd, vd >> lit);
            tinker_pkg::OP_SHFTL:  model_write_reg(rd, vs << vt);
            tinker_pkg::OP_SHFTLI: model_write_reg(rd, vd << lit);
            tinker_pkg::OP_ADD:    model_write_reg(rd, vs + vt);
            tinker_pkg::OP_ADDI:   model_write_reg(rd, vd + lit);
            tinker_pkg::OP_SUB:    model_write_reg(rd, vs - vt);
            tinker_pkg::OP_SUBI:   model_write_reg(rd, vd - lit);
            tinker_pkg::OP_MOV_RS: model_write_reg(rd, vs);
            tinker_pkg::OP_MOV_L:  model_write_reg(rd, {vd[63:12], ins[11:0]});
            tinker_pkg::OP_LOAD:   model_write_reg(rd, model_read64(32'(vs + lit)));
            tinker_pkg::OP_STORE:
                for (int i = 0; i < 8; i++)
                    model_mem[32'(vd + lit) + i] = vs[8*i +: 8];
            // target counts from the branch itself, in words
            tinker_pkg::OP_BRR_L:  pc = pc - 32'd4 + {{18{ins[11]}}, ins[11:0], 2'b00};
            default: ;
        endcase
    end
endtask

`endif

// File: testbench/tinker_tb.sv
`timescale 1ns/10ps

module tinker_tb;

    localparam int          N_INSTR    = 60;
    localparam int          CLK_PERIOD = 100;
    localparam int          WATCHDOG   = 16 + 3 * N_INSTR + 40;  // cycles
    localparam logic [31:0] SEED       = 32'h011a4402;
    localparam tinker_pkg::opcode_e ALU_OPS [14] = '{
        tinker_pkg::OP_AND, tinker_pkg::OP_OR, tinker_pkg::OP_XOR, tinker_pkg::OP_NOT,
        tinker_pkg::OP_SHFTR, tinker_pkg::OP_SHFTRI, tinker_pkg::OP_SHFTL,
        tinker_pkg::OP_SHFTLI, tinker_pkg::OP_ADD, tinker_pkg::OP_ADDI, tinker_pkg::OP_SUB,
        tinker_pkg::OP_SUBI, tinker_pkg::OP_MOV_RS, tinker_pkg::OP_MOV_L
    };

    logic        clk;
    logic        reset;
    logic        hlt;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [63:0] wb_data;

    int          n_instr;     // words emitted so far
    int          wb_count;
    int          n_expected;
    bit          hlt_seen;
    logic [4:0]  recent [$];  // last few destinations to force forwarding
    logic [31:0] stored [$];  // data addresses written by earlier stores

    tinker_core u_dut (.*);

    `include "tinker_model.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // every address bit reaches the byte value
    function automatic logic [7:0] fill_byte(input int addr);
        return 8'(addr ^ ((addr >> 8) * 37) ^ 8'h6b);
    endfunction

    // one word into DUT memory and model memory alike
    task automatic emit(input tinker_pkg::opcode_e op, input logic [4:0] rd, rs, rt,
                        input logic [11:0] lit);
        logic [31:0] ins;
        logic [31:0] addr;
        ins  = {op, rd, rs, rt, lit};
        addr = tinker_pkg::PC_RESET_ADDR + 4 * n_instr;
        for (int i = 0; i < 4; i++) begin
            u_dut.u_memory.mem_bytes[addr + i] = ins[8*i +: 8];
            model_mem[addr + i] = ins[8*i +: 8];
        end
        n_instr++;
    endtask

    function automatic logic [4:0] pick_src();
        if (recent.size() > 0 && $urandom % 100 < 60)
            return recent[$urandom % recent.size()];
        return 5'($urandom % 32);
    endfunction

    function automatic logic [4:0] pick_dst();
        logic [4:0] r;
        if (recent.size() > 0 && $urandom % 100 < 30)
            r = recent[$urandom % recent.size()];
        else
            r = 5'($urandom % 32);  // r0 now and then and its write is dropped
        recent.push_back(r);
        if (recent.size() > 4)
            void'(recent.pop_front());
        return r;
    endfunction

    task automatic emit_alu();
        tinker_pkg::opcode_e op;
        logic [4:0]          rd, rs, rt;
        logic [11:0]         lit;
        op  = ALU_OPS[$urandom % 14];
        rs  = pick_src();
        rt  = pick_src();
        rd  = pick_dst();
        lit = 12'($urandom);
        if (op == tinker_pkg::OP_SHFTRI || op == tinker_pkg::OP_SHFTLI)
            lit = 12'($urandom % 64);  // keep some bits alive
        emit(op, rd, rs, rt, lit);
    endtask

    // base cleared and set with mov rd,L before the access at base + L
    task automatic emit_mem();
        logic [4:0]  base;
        logic [31:0] addr;
        logic [11:0] off;
        base = 5'(1 + $urandom % 31);
        if (stored.size() > 0 && $urandom % 2 == 0)
            addr = stored[$urandom % stored.size()];  // read back an earlier store
        else
            addr = 32'(($urandom % 512) * 8);
        off = 12'(($urandom % 8) * 8);
        if (32'(off) > addr)
            off = 12'(addr);
        emit(tinker_pkg::OP_XOR, base, base, base, 12'd0);
        emit(tinker_pkg::OP_MOV_L, base, 5'd0, 5'd0, 12'(addr) - off);
        if ($urandom % 2 == 0) begin
            emit(tinker_pkg::OP_STORE, base, pick_src(), 5'd0, off);
            stored.push_back(addr);
        end else begin
            emit(tinker_pkg::OP_LOAD, pick_dst(), base, 5'd0, off);
        end
    endtask

    // skipped words are plain ALU ops and the target starts a group
    task automatic emit_branch(input int skip);
        emit(tinker_pkg::OP_BRR_L, 5'd0, 5'd0, 5'd0, 12'(skip + 1));
        repeat (skip) emit_alu();
    endtask

    task automatic build_program();
        int room;
        while (n_instr < N_INSTR - 1) begin
            room = N_INSTR - 1 - n_instr;  // halt gets the last word
            case ($urandom % 8)
                0, 1: if (room >= 3) emit_mem(); else emit_alu();
                2: if (room >= 4) emit_branch($urandom % 3); else emit_alu();
                default: emit_alu();
            endcase
        end
        emit(tinker_pkg::OP_HALT, 5'd0, 5'd0, 5'd0, 12'd0);
    endtask

    task automatic check_writeback();
        assert (exp_rd_q.size() > 0) else
            report_failure($sformatf("writeback to r%0d at %0t that the model never made",
                                     wb_rd, $time));
        assert (wb_rd === exp_rd_q[0] && wb_data === exp_data_q[0]) else
            report_failure($sformatf("FAIL %0t: wb r%0d=%h, expected r%0d=%h", $time,
                                     wb_rd, wb_data, exp_rd_q[0], exp_data_q[0]));
        void'(exp_rd_q.pop_front());
        void'(exp_data_q.pop_front());
        wb_count++;
    endtask

    // outputs settle after the rising edge so look half a period later
    always @(negedge clk) begin
        if (reset) begin
            assert (hlt === 1'b0 && wb_valid === 1'b0) else
                report_failure($sformatf("FAIL %0t: hlt or wb_valid high in reset", $time));
        end else begin
            if (hlt_seen)
                assert (hlt === 1'b1) else
                    report_failure($sformatf("FAIL %0t: hlt dropped after rising", $time));
            if (wb_valid)
                check_writeback();
            if (hlt && !hlt_seen) begin
                assert (exp_rd_q.size() == 0) else
                    report_failure("hlt rose while expected writebacks were still pending");
                hlt_seen = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG * CLK_PERIOD);
        report_failure($sformatf("timeout, hlt not reached within %0d cycles", WATCHDOG));
    end

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        wb_count = 0;
        hlt_seen = 1'b0;
        n_instr  = 0;
        void'($urandom(SEED));
        for (int a = 0; a < tinker_pkg::MEM_BYTES; a++) begin
            u_dut.u_memory.mem_bytes[a] = fill_byte(a);
            model_mem[a] = fill_byte(a);
        end
        build_program();
        run_model();
        n_expected = exp_rd_q.size();
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        wait (hlt === 1'b1);
        repeat (8) @(posedge clk);  // hlt has to hold with no late writebacks
        assert (wb_count == n_expected) else
            report_failure($sformatf("FAIL %0t: %0d writebacks, model expects %0d",
                                     $time, wb_count, n_expected));
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+testbench
logic/tinker_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/register_file.sv
logic/hazard_unit.sv
logic/execute_unit.sv
logic/memory_unit.sv
logic/tinker_core.sv
testbench/tinker_tb.sv

// File: Bender.yml
package:
  name: tinker

sources:
  - logic/tinker_pkg.sv
  - logic/fetch_unit.sv
  - logic/decode_unit.sv
  - logic/register_file.sv
  - logic/hazard_unit.sv
  - logic/execute_unit.sv
  - logic/memory_unit.sv
  - logic/tinker_core.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tinker_tb.sv
